// File: src/ts_stream_pkg.sv
`default_nettype none

package ts_stream_pkg;

	// transport stream framing
	localparam int PACK_BYTE_SIZE = 188;
	localparam logic [7:0] SYNC_BYTE = 8'h47;

	// filter table
	localparam int SLOT_COUNT = 4;
	localparam int SLOT_BITS = 2;
	localparam int PID_BITS = 13;

	// cycles from mpeg_data to ts_out
	localparam int PIPE_DEPTH = 3;

	// byte position inside a packet
	localparam int INDEX_BITS = 8;

endpackage

`default_nettype wire

// File: src/ts_regs_pkg.sv
`default_nettype none

package ts_regs_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_BITS = 2;

	// word addresses
	localparam logic [ADDR_BITS-1:0] ADDR_CTRL = 2'd0;
	localparam logic [ADDR_BITS-1:0] ADDR_REPLACE_DATA = 2'd1;
	localparam logic [ADDR_BITS-1:0] ADDR_MON_STATUS = 2'd2;
	localparam logic [ADDR_BITS-1:0] ADDR_MON_DATA = 2'd3;

	// op bits of the ctrl word
	localparam int OP_REPLACE_ADD = 0;
	localparam int OP_REPLACE_DEL = 1;
	localparam int OP_MONITOR_ADD = 2;
	localparam int OP_MONITOR_DEL = 3;

	typedef struct packed {
		logic [3:0] rsvd_hi;
		logic [7:0] slot;
		logic [2:0] rsvd_mid;
		logic [ts_stream_pkg::PID_BITS-1:0] pid;
		logic [3:0] op;
	} ctrl_cmd_t;

	// all op bits zero picks a monitor buffer and where reading starts
	typedef struct packed {
		logic [3:0] rsvd_hi;
		logic [7:0] slot;
		logic [7:0] rsvd_mid;
		logic [ts_stream_pkg::INDEX_BITS-1:0] offset;
		logic [3:0] op;
	} ctrl_sel_t;

	typedef union packed {
		ctrl_cmd_t cmd;
		ctrl_sel_t sel;
	} ctrl_word_u;

endpackage

`default_nettype wire

// File: src/ts_filter_regs.sv
`timescale 1ns/10ps
`default_nettype none

module ts_filter_regs (
	input wire S_AXI_ACLK,
	input wire mpeg_clk,
	input wire mem_wren,
	input wire mem_rden,
	input wire [ts_regs_pkg::ADDR_BITS-1:0] mem_address,
	input wire [ts_regs_pkg::DATA_WIDTH-1:0] S_AXI_WDATA,
	output logic [ts_regs_pkg::DATA_WIDTH-1:0] axi_rdata,
	output logic [ts_stream_pkg::SLOT_COUNT-1:0][ts_stream_pkg::PID_BITS-1:0] slot_pid,
	output logic [ts_stream_pkg::SLOT_COUNT-1:0] slot_replace_en,
	output logic [ts_stream_pkg::SLOT_COUNT-1:0] slot_monitor_en,
	input wire [ts_stream_pkg::INDEX_BITS-1:0] replace_index,
	output logic [7:0] replace_byte,
	input wire [ts_stream_pkg::SLOT_COUNT-1:0] mon_ready,
	output logic [ts_stream_pkg::SLOT_COUNT-1:0] mon_clear,
	output logic [ts_stream_pkg::SLOT_BITS-1:0] mon_rd_slot,
	output logic [ts_stream_pkg::INDEX_BITS-1:0] mon_rd_index,
	input wire [7:0] mon_rd_data
);

	ts_regs_pkg::ctrl_word_u ctrl;
	logic [ts_stream_pkg::SLOT_BITS-1:0] cmd_slot;
	logic [7:0] replace_mem [ts_stream_pkg::PACK_BYTE_SIZE];
	logic [ts_stream_pkg::INDEX_BITS-1:0] repl_cursor;
	logic [ts_regs_pkg::DATA_WIDTH-1:0] status_word;
	logic [ts_regs_pkg::DATA_WIDTH-1:0] data_word;

	assign ctrl = S_AXI_WDATA;
	assign cmd_slot = ctrl.cmd.slot[ts_stream_pkg::SLOT_BITS-1:0];
	assign status_word = {{(ts_regs_pkg::DATA_WIDTH - ts_stream_pkg::SLOT_COUNT){1'b0}},
		mon_ready};
	assign data_word = {{(ts_regs_pkg::DATA_WIDTH - 8){1'b0}}, mon_rd_data};

	// filter reads the replacement packet directly
	assign replace_byte = replace_mem[replace_index];

	always_ff @(posedge S_AXI_ACLK or posedge mpeg_clk) begin
		if (mpeg_clk) begin
			slot_pid <= '0;
			slot_replace_en <= '0;
			slot_monitor_en <= '0;
			mon_clear <= '0;
			mon_rd_slot <= '0;
			mon_rd_index <= '0;
			repl_cursor <= '0;
			for (int i = 0; i < ts_stream_pkg::PACK_BYTE_SIZE; i++)
				replace_mem[i] <= '0;
		end else begin
			mon_clear <= '0;
			// each data read steps through the selected buffer
			if (mem_rden && mem_address == ts_regs_pkg::ADDR_MON_DATA) begin
				if (mon_rd_index == ts_stream_pkg::PACK_BYTE_SIZE - 1)
					mon_rd_index <= '0;
				else
					mon_rd_index <= mon_rd_index + 1'b1;
			end
			if (mem_wren) begin
				case (mem_address)
					ts_regs_pkg::ADDR_CTRL: begin
						repl_cursor <= '0;
						if (ctrl.sel.op == '0) begin
							mon_rd_slot <= ctrl.sel.slot[ts_stream_pkg::SLOT_BITS-1:0];
							mon_rd_index <= ctrl.sel.offset;
						end else begin
							if (ctrl.cmd.op[ts_regs_pkg::OP_REPLACE_ADD] ||
								ctrl.cmd.op[ts_regs_pkg::OP_MONITOR_ADD])
								slot_pid[cmd_slot] <= ctrl.cmd.pid;
							if (ctrl.cmd.op[ts_regs_pkg::OP_REPLACE_ADD])
								slot_replace_en[cmd_slot] <= 1'b1;
							if (ctrl.cmd.op[ts_regs_pkg::OP_REPLACE_DEL])
								slot_replace_en[cmd_slot] <= 1'b0;
							if (ctrl.cmd.op[ts_regs_pkg::OP_MONITOR_ADD])
								slot_monitor_en[cmd_slot] <= 1'b1;
							if (ctrl.cmd.op[ts_regs_pkg::OP_MONITOR_DEL])
								slot_monitor_en[cmd_slot] <= 1'b0;
						end
					end
					ts_regs_pkg::ADDR_REPLACE_DATA: begin
						// low byte only
						replace_mem[repl_cursor] <= S_AXI_WDATA[7:0];
						if (repl_cursor == ts_stream_pkg::PACK_BYTE_SIZE - 1)
							repl_cursor <= '0;
						else
							repl_cursor <= repl_cursor + 1'b1;
					end
					ts_regs_pkg::ADDR_MON_STATUS:
						mon_clear <= S_AXI_WDATA[ts_stream_pkg::SLOT_COUNT-1:0];
					default: ;
				endcase
			end
		end
	end

	// read data holds until the next read
	always_ff @(posedge S_AXI_ACLK or posedge mpeg_clk) begin
		if (mpeg_clk) begin
			axi_rdata <= '0;
		end else if (mem_rden) begin
			case (mem_address)
				ts_regs_pkg::ADDR_MON_STATUS: axi_rdata <= status_word;
				ts_regs_pkg::ADDR_MON_DATA: axi_rdata <= data_word;
				default: axi_rdata <= '0;
			endcase
		end
	end

	a_cursor_range: assert property (@(posedge S_AXI_ACLK) disable iff (mpeg_clk)
		repl_cursor < ts_stream_pkg::PACK_BYTE_SIZE);

endmodule

`default_nettype wire

// File: src/ts_pid_filter.sv
`timescale 1ns/10ps
`default_nettype none

module ts_pid_filter (
	input wire S_AXI_ACLK,
	input wire mpeg_clk,
	input wire [7:0] mpeg_data,
	input wire mpeg_valid,
	input wire mpeg_sync,
	input wire [ts_stream_pkg::SLOT_COUNT-1:0][ts_stream_pkg::PID_BITS-1:0] slot_pid,
	input wire [ts_stream_pkg::SLOT_COUNT-1:0] slot_replace_en,
	input wire [ts_stream_pkg::SLOT_COUNT-1:0] slot_monitor_en,
	output logic [ts_stream_pkg::INDEX_BITS-1:0] replace_index,
	input wire [7:0] replace_byte,
	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync,
	output logic cap_start,
	output logic [ts_stream_pkg::SLOT_BITS-1:0] cap_slot,
	output logic cap_valid,
	output logic [7:0] cap_data
);

	// stage 0 is newest, stage PIPE_DEPTH-1 drives the output
	logic [7:0] d_data [ts_stream_pkg::PIPE_DEPTH];
	logic [ts_stream_pkg::PIPE_DEPTH-1:0] d_valid;
	logic [ts_stream_pkg::PIPE_DEPTH-1:0] d_sync;
	logic [ts_stream_pkg::PID_BITS-1:0] hdr_pid;
	logic pkt_start;
	logic replace_hit;
	logic mon_hit;
	logic [ts_stream_pkg::SLOT_BITS-1:0] hit_slot;
	logic [ts_stream_pkg::INDEX_BITS-1:0] byte_cnt;
	logic repl_flag;
	logic mon_flag;
	logic [ts_stream_pkg::SLOT_BITS-1:0] mon_slot;
	logic repl_now;
	logic mon_now;

	always_ff @(posedge S_AXI_ACLK or posedge mpeg_clk) begin
		if (mpeg_clk) begin
			d_valid <= '0;
			d_sync <= '0;
		end else begin
			d_valid <= {d_valid[ts_stream_pkg::PIPE_DEPTH-2:0], mpeg_valid};
			d_sync <= {d_sync[ts_stream_pkg::PIPE_DEPTH-2:0], mpeg_sync};
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		d_data[0] <= mpeg_data;
		for (int i = 1; i < ts_stream_pkg::PIPE_DEPTH; i++)
			d_data[i] <= d_data[i-1];
	end

	// sync byte at the last stage, header bytes 1 and 2 right behind it
	assign pkt_start = d_valid[ts_stream_pkg::PIPE_DEPTH-1] & d_sync[ts_stream_pkg::PIPE_DEPTH-1];
	assign hdr_pid = {d_data[ts_stream_pkg::PIPE_DEPTH-2][4:0],
		d_data[ts_stream_pkg::PIPE_DEPTH-3]};

	// walk down so the lowest matching slot is the one left standing
	always_comb begin
		replace_hit = 1'b0;
		mon_hit = 1'b0;
		hit_slot = '0;
		for (int i = ts_stream_pkg::SLOT_COUNT - 1; i >= 0; i--) begin
			if (slot_replace_en[i] && slot_pid[i] == hdr_pid)
				replace_hit = 1'b1;
			if (slot_monitor_en[i] && slot_pid[i] == hdr_pid) begin
				mon_hit = 1'b1;
				hit_slot = i[ts_stream_pkg::SLOT_BITS-1:0];
			end
		end
	end

	// byte_cnt of zero means no packet in progress
	always_ff @(posedge S_AXI_ACLK or posedge mpeg_clk) begin
		if (mpeg_clk) begin
			byte_cnt <= '0;
			repl_flag <= 1'b0;
			mon_flag <= 1'b0;
			mon_slot <= '0;
		end else if (pkt_start) begin
			byte_cnt <= ts_stream_pkg::INDEX_BITS'(1);
			repl_flag <= replace_hit;
			mon_flag <= mon_hit;
			mon_slot <= hit_slot;
		end else if (byte_cnt != '0 && d_valid[ts_stream_pkg::PIPE_DEPTH-1]) begin
			if (byte_cnt == ts_stream_pkg::PACK_BYTE_SIZE - 1) begin
				byte_cnt <= '0;
				repl_flag <= 1'b0;
				mon_flag <= 1'b0;
			end else begin
				byte_cnt <= byte_cnt + 1'b1;
			end
		end
	end

	// header cycle uses the fresh match, the rest of the packet the latched one
	assign repl_now = pkt_start ? replace_hit : repl_flag;
	assign mon_now = pkt_start ? mon_hit : mon_flag;

	assign replace_index = byte_cnt;
	assign ts_out = repl_now ? replace_byte : d_data[ts_stream_pkg::PIPE_DEPTH-1];
	assign ts_out_valid = d_valid[ts_stream_pkg::PIPE_DEPTH-1];
	assign ts_out_sync = d_sync[ts_stream_pkg::PIPE_DEPTH-1];

	// capture always sees the original bytes
	assign cap_start = pkt_start & mon_hit;
	assign cap_slot = pkt_start ? hit_slot : mon_slot;
	assign cap_valid = d_valid[ts_stream_pkg::PIPE_DEPTH-1] & mon_now;
	assign cap_data = d_data[ts_stream_pkg::PIPE_DEPTH-1];

	a_sync_valid: assert property (@(posedge S_AXI_ACLK) disable iff (mpeg_clk)
		mpeg_sync |-> mpeg_valid);

	// input runs PIPE_DEPTH bytes ahead of the counter
	a_valid_contig: assert property (@(posedge S_AXI_ACLK) disable iff (mpeg_clk)
		(byte_cnt != '0 &&
			byte_cnt < ts_stream_pkg::PACK_BYTE_SIZE - ts_stream_pkg::PIPE_DEPTH)
		|-> mpeg_valid);

endmodule

`default_nettype wire

// File: src/ts_monitor_capture.sv
`timescale 1ns/10ps
`default_nettype none

module ts_monitor_capture (
	input wire S_AXI_ACLK,
	input wire mpeg_clk,
	input wire cap_start,
	input wire [ts_stream_pkg::SLOT_BITS-1:0] cap_slot,
	input wire cap_valid,
	input wire [7:0] cap_data,
	input wire [ts_stream_pkg::SLOT_COUNT-1:0] mon_clear,
	output logic [ts_stream_pkg::SLOT_COUNT-1:0] mon_ready,
	input wire [ts_stream_pkg::SLOT_BITS-1:0] mon_rd_slot,
	input wire [ts_stream_pkg::INDEX_BITS-1:0] mon_rd_index,
	output logic [7:0] mon_rd_data
);

	logic [7:0] cap_mem [ts_stream_pkg::SLOT_COUNT][ts_stream_pkg::PACK_BYTE_SIZE];
	logic active;
	logic [ts_stream_pkg::SLOT_BITS-1:0] act_slot;
	logic [ts_stream_pkg::INDEX_BITS-1:0] wr_index;
	logic start_ok;
	logic wr_en;
	logic [ts_stream_pkg::SLOT_BITS-1:0] wr_slot;
	logic [ts_stream_pkg::INDEX_BITS-1:0] wr_addr;
	logic [ts_stream_pkg::SLOT_COUNT-1:0] done_mask;

	// a full buffer keeps its packet until software clears it
	assign start_ok = cap_start & ~mon_ready[cap_slot];

	// header byte arrives together with cap_start
	assign wr_en = cap_valid & (start_ok | active);
	assign wr_slot = start_ok ? cap_slot : act_slot;
	assign wr_addr = start_ok ? '0 : wr_index;

	assign mon_rd_data = cap_mem[mon_rd_slot][mon_rd_index];

	always_comb begin
		done_mask = '0;
		if (active && cap_valid && wr_index == ts_stream_pkg::PACK_BYTE_SIZE - 1)
			done_mask[act_slot] = 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_en)
			cap_mem[wr_slot][wr_addr] <= cap_data;
	end

	always_ff @(posedge S_AXI_ACLK or posedge mpeg_clk) begin
		if (mpeg_clk) begin
			active <= 1'b0;
			act_slot <= '0;
			wr_index <= '0;
			mon_ready <= '0;
		end else begin
			mon_ready <= (mon_ready & ~mon_clear) | done_mask;
			if (start_ok) begin
				active <= 1'b1;
				act_slot <= cap_slot;
				wr_index <= ts_stream_pkg::INDEX_BITS'(1);
			end else if (active && cap_valid) begin
				if (done_mask != '0) begin
					active <= 1'b0;
					wr_index <= '0;
				end else begin
					wr_index <= wr_index + 1'b1;
				end
			end
		end
	end

	a_index_range: assert property (@(posedge S_AXI_ACLK) disable iff (mpeg_clk)
		active |-> wr_index < ts_stream_pkg::PACK_BYTE_SIZE);

endmodule

`default_nettype wire

// File: src/ts_remux_top.sv
`timescale 1ns/10ps
`default_nettype none

module ts_remux_top (
	input wire S_AXI_ACLK,
	input wire mpeg_clk,
	input wire [7:0] mpeg_data,
	input wire mpeg_valid,
	input wire mpeg_sync,
	input wire mem_wren,
	input wire mem_rden,
	input wire [ts_regs_pkg::ADDR_BITS-1:0] mem_address,
	input wire [ts_regs_pkg::DATA_WIDTH-1:0] S_AXI_WDATA,
	// byte strobes not supported, every write is a full word
	input wire [(ts_regs_pkg::DATA_WIDTH/8)-1:0] S_AXI_WSTRB,
	output logic [ts_regs_pkg::DATA_WIDTH-1:0] axi_rdata,
	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync,
	output logic monitor_ready
);

	logic [ts_stream_pkg::SLOT_COUNT-1:0][ts_stream_pkg::PID_BITS-1:0] slot_pid;
	logic [ts_stream_pkg::SLOT_COUNT-1:0] slot_replace_en;
	logic [ts_stream_pkg::SLOT_COUNT-1:0] slot_monitor_en;
	logic [ts_stream_pkg::INDEX_BITS-1:0] replace_index;
	logic [7:0] replace_byte;
	logic cap_start;
	logic [ts_stream_pkg::SLOT_BITS-1:0] cap_slot;
	logic cap_valid;
	logic [7:0] cap_data;
	logic [ts_stream_pkg::SLOT_COUNT-1:0] mon_ready;
	logic [ts_stream_pkg::SLOT_COUNT-1:0] mon_clear;
	logic [ts_stream_pkg::SLOT_BITS-1:0] mon_rd_slot;
	logic [ts_stream_pkg::INDEX_BITS-1:0] mon_rd_index;
	logic [7:0] mon_rd_data;

	ts_filter_regs i_regs (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.mpeg_clk        (mpeg_clk),
		.mem_wren        (mem_wren),
		.mem_rden        (mem_rden),
		.mem_address     (mem_address),
		.S_AXI_WDATA     (S_AXI_WDATA),
		.axi_rdata       (axi_rdata),
		.slot_pid        (slot_pid),
		.slot_replace_en (slot_replace_en),
		.slot_monitor_en (slot_monitor_en),
		.replace_index   (replace_index),
		.replace_byte    (replace_byte),
		.mon_ready       (mon_ready),
		.mon_clear       (mon_clear),
		.mon_rd_slot     (mon_rd_slot),
		.mon_rd_index    (mon_rd_index),
		.mon_rd_data     (mon_rd_data)
	);

	ts_pid_filter i_filter (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.mpeg_clk        (mpeg_clk),
		.mpeg_data       (mpeg_data),
		.mpeg_valid      (mpeg_valid),
		.mpeg_sync       (mpeg_sync),
		.slot_pid        (slot_pid),
		.slot_replace_en (slot_replace_en),
		.slot_monitor_en (slot_monitor_en),
		.replace_index   (replace_index),
		.replace_byte    (replace_byte),
		.ts_out          (ts_out),
		.ts_out_valid    (ts_out_valid),
		.ts_out_sync     (ts_out_sync),
		.cap_start       (cap_start),
		.cap_slot        (cap_slot),
		.cap_valid       (cap_valid),
		.cap_data        (cap_data)
	);

	ts_monitor_capture i_capture (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.mpeg_clk     (mpeg_clk),
		.cap_start    (cap_start),
		.cap_slot     (cap_slot),
		.cap_valid    (cap_valid),
		.cap_data     (cap_data),
		.mon_clear    (mon_clear),
		.mon_ready    (mon_ready),
		.mon_rd_slot  (mon_rd_slot),
		.mon_rd_index (mon_rd_index),
		.mon_rd_data  (mon_rd_data)
	);

	// any slot holding a captured packet
	assign monitor_ready = |mon_ready;

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

endmodule

`default_nettype wire

// File: bench/tb_ts_tasks.svh
`ifndef TB_TS_TASKS_SVH
`define TB_TS_TASKS_SVH

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp) begin
		$display("Error at time %0t: %s expected %h actual %h", $time, name, exp, act);
		error_count++;
	end
endtask

task automatic check_word(input string name, input logic [ts_regs_pkg::DATA_WIDTH-1:0] exp,
	input logic [ts_regs_pkg::DATA_WIDTH-1:0] act);
	if (act !== exp) begin
		$display("Error at time %0t: %s expected %h actual %h", $time, name, exp, act);
		error_count++;
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("Error at time %0t: %s expected %b actual %b", $time, name, exp, act);
		error_count++;
	end
endtask

task automatic reg_write(input logic [ts_regs_pkg::ADDR_BITS-1:0] addr,
	input logic [ts_regs_pkg::DATA_WIDTH-1:0] data);
	@(negedge S_AXI_ACLK);
	mem_wren = 1'b1;
	mem_address = addr;
	S_AXI_WDATA = data;
	@(negedge S_AXI_ACLK);
	mem_wren = 1'b0;
endtask

task automatic reg_read(input logic [ts_regs_pkg::ADDR_BITS-1:0] addr,
	output logic [ts_regs_pkg::DATA_WIDTH-1:0] data);
	@(negedge S_AXI_ACLK);
	mem_rden = 1'b1;
	mem_address = addr;
	@(negedge S_AXI_ACLK);
	mem_rden = 1'b0;
	data = axi_rdata;
endtask

task automatic ctrl_write(input logic [3:0] op, input logic [ts_stream_pkg::PID_BITS-1:0] pid,
	input int slot);
	ts_regs_pkg::ctrl_word_u w;
	w = '0;
	w.cmd.op = op;
	w.cmd.pid = pid;
	w.cmd.slot = 8'(slot);
	reg_write(ts_regs_pkg::ADDR_CTRL, w);
endtask

// no op bits selects a buffer with a read offset
task automatic select_buffer(input int slot, input logic [7:0] offset);
	ts_regs_pkg::ctrl_word_u w;
	w = '0;
	w.sel.slot = 8'(slot);
	w.sel.offset = offset;
	reg_write(ts_regs_pkg::ADDR_CTRL, w);
endtask

task automatic send_packet(input logic [ts_stream_pkg::PID_BITS-1:0] pid);
	last_pkt[0] = ts_stream_pkg::SYNC_BYTE;
	last_pkt[1] = {3'b010, pid[12:8]};
	last_pkt[2] = pid[7:0];
	last_pkt[3] = 8'h10;
	for (int i = 4; i < ts_stream_pkg::PACK_BYTE_SIZE; i++)
		last_pkt[i] = 8'($random(seed));
	for (int i = 0; i < ts_stream_pkg::PACK_BYTE_SIZE; i++) begin
		@(negedge S_AXI_ACLK);
		mpeg_valid = 1'b1;
		mpeg_sync = (i == 0);
		mpeg_data = last_pkt[i];
	end
	@(negedge S_AXI_ACLK);
	mpeg_valid = 1'b0;
	mpeg_sync = 1'b0;
endtask

task automatic send_and_check(input logic [ts_stream_pkg::PID_BITS-1:0] pid,
	input bit expect_repl);
	int waited;
	out_q.delete();
	sync_q.delete();
	send_packet(pid);
	waited = 0;
	// the packet is complete once all bytes are out and the output goes idle
	while ((out_q.size() < ts_stream_pkg::PACK_BYTE_SIZE || ts_out_valid) &&
		waited < 20) begin
		@(negedge S_AXI_ACLK);
		waited++;
	end
	if (ts_out_valid) begin
		$display("timeout: output for PID %h did not go idle after %0d bytes",
			pid, out_q.size());
		timeout_count++;
	end else if (out_q.size() != ts_stream_pkg::PACK_BYTE_SIZE) begin
		$display("output packet for PID %h has %0d bytes instead of %0d",
			pid, out_q.size(), ts_stream_pkg::PACK_BYTE_SIZE);
		error_count++;
	end else begin
		for (int i = 0; i < ts_stream_pkg::PACK_BYTE_SIZE; i++) begin
			check_byte("ts_out", expect_repl ? repl_pkt[i] : last_pkt[i], out_q[i]);
			check_bit("ts_out_sync", i == 0, sync_q[i]);
		end
	end
endtask

task automatic wait_ready(input logic exp);
	int waited;
	waited = 0;
	while (monitor_ready !== exp && waited < 20) begin
		@(negedge S_AXI_ACLK);
		waited++;
	end
	if (monitor_ready !== exp) begin
		$display("timeout: monitor_ready never became %b", exp);
		timeout_count++;
	end
endtask

task automatic load_replacement();
	repl_pkt[0] = ts_stream_pkg::SYNC_BYTE;
	repl_pkt[1] = 8'h1f;
	repl_pkt[2] = 8'hff;
	repl_pkt[3] = 8'h10;
	for (int i = 4; i < ts_stream_pkg::PACK_BYTE_SIZE; i++)
		repl_pkt[i] = 8'($random(seed));
	// a ctrl write rewinds the cursor
	select_buffer(0, 8'd0);
	for (int i = 0; i < ts_stream_pkg::PACK_BYTE_SIZE; i++)
		reg_write(ts_regs_pkg::ADDR_REPLACE_DATA, ts_regs_pkg::DATA_WIDTH'(repl_pkt[i]));
endtask

task automatic verify_status(input logic [ts_regs_pkg::DATA_WIDTH-1:0] exp);
	logic [ts_regs_pkg::DATA_WIDTH-1:0] word;
	reg_read(ts_regs_pkg::ADDR_MON_STATUS, word);
	check_word("mon_status", exp, word);
endtask

task automatic verify_buffer(input int slot);
	logic [ts_regs_pkg::DATA_WIDTH-1:0] word;
	select_buffer(slot, 8'd0);
	for (int i = 0; i < ts_stream_pkg::PACK_BYTE_SIZE; i++) begin
		reg_read(ts_regs_pkg::ADDR_MON_DATA, word);
		check_word("mon_data", ts_regs_pkg::DATA_WIDTH'(cap_ref[i]), word);
	end
endtask

task automatic passthrough_packets();
	send_and_check(13'h0100, 1'b0);
	send_and_check(13'h1fff, 1'b0);
endtask

task automatic replace_packets();
	load_replacement();
	ctrl_write(4'(1 << ts_regs_pkg::OP_REPLACE_ADD), 13'h0abc, 1);
	send_and_check(13'h0abc, 1'b1);
	send_and_check(13'h0123, 1'b0);
	send_and_check(13'h0abc, 1'b1);
	ctrl_write(4'(1 << ts_regs_pkg::OP_REPLACE_DEL), 13'h0000, 1);
	send_and_check(13'h0abc, 1'b0);
endtask

task automatic monitor_capture();
	ctrl_write(4'(1 << ts_regs_pkg::OP_MONITOR_ADD), 13'h0200, 2);
	send_and_check(13'h0200, 1'b0);
	cap_ref = last_pkt;
	wait_ready(1'b1);
	verify_status(32'h4);
	verify_buffer(2);
endtask

task automatic ready_hold_and_clear();
	// buffer is full, this packet must be ignored
	send_and_check(13'h0200, 1'b0);
	check_bit("monitor_ready", 1'b1, monitor_ready);
	verify_status(32'h4);
	verify_buffer(2);
	reg_write(ts_regs_pkg::ADDR_MON_STATUS, 32'h4);
	wait_ready(1'b0);
	send_and_check(13'h0200, 1'b0);
	cap_ref = last_pkt;
	wait_ready(1'b1);
	verify_buffer(2);
	reg_write(ts_regs_pkg::ADDR_MON_STATUS, 32'h4);
	wait_ready(1'b0);
	ctrl_write(4'(1 << ts_regs_pkg::OP_MONITOR_DEL), 13'h0000, 2);
endtask

task automatic combined_priority();
	ctrl_write(4'(1 << ts_regs_pkg::OP_REPLACE_ADD), 13'h0777, 0);
	ctrl_write(4'(1 << ts_regs_pkg::OP_MONITOR_ADD), 13'h0777, 1);
	ctrl_write(4'(1 << ts_regs_pkg::OP_MONITOR_ADD), 13'h0777, 3);
	send_and_check(13'h0777, 1'b1);
	cap_ref = last_pkt;
	wait_ready(1'b1);
	// slot 1 wins over slot 3
	verify_status(32'h2);
	verify_buffer(1);
	reg_write(ts_regs_pkg::ADDR_MON_STATUS, 32'h2);
	wait_ready(1'b0);
endtask

`endif

// File: bench/tb_ts_remux.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ts_remux;

	logic S_AXI_ACLK;
	logic mpeg_clk;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic mem_wren;
	logic mem_rden;
	logic [ts_regs_pkg::ADDR_BITS-1:0] mem_address;
	logic [ts_regs_pkg::DATA_WIDTH-1:0] S_AXI_WDATA;
	logic [(ts_regs_pkg::DATA_WIDTH/8)-1:0] S_AXI_WSTRB;
	logic [ts_regs_pkg::DATA_WIDTH-1:0] axi_rdata;
	logic [7:0] ts_out;
	logic ts_out_valid;
	logic ts_out_sync;
	logic monitor_ready;

	integer seed;
	int error_count;
	int timeout_count;
	logic [7:0] out_q [$];
	logic sync_q [$];
	logic [7:0] last_pkt [ts_stream_pkg::PACK_BYTE_SIZE];
	logic [7:0] repl_pkt [ts_stream_pkg::PACK_BYTE_SIZE];
	logic [7:0] cap_ref [ts_stream_pkg::PACK_BYTE_SIZE];

	tb_clock i_clock (
		.clk (S_AXI_ACLK)
	);

	ts_remux_top i_dut (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.mpeg_clk      (mpeg_clk),
		.mpeg_data     (mpeg_data),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.mem_wren      (mem_wren),
		.mem_rden      (mem_rden),
		.mem_address   (mem_address),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.axi_rdata     (axi_rdata),
		.ts_out        (ts_out),
		.ts_out_valid  (ts_out_valid),
		.ts_out_sync   (ts_out_sync),
		.monitor_ready (monitor_ready)
	);

	`include "tb_ts_tasks.svh"

	// outputs change on the rising edge and are stable at the falling one
	always @(negedge S_AXI_ACLK) begin
		if (!mpeg_clk && ts_out_valid) begin
			out_q.push_back(ts_out);
			sync_q.push_back(ts_out_sync);
		end
	end

	initial begin
		seed = 23771;
		error_count = 0;
		timeout_count = 0;
		mpeg_clk = 1'b1;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		mem_wren = 1'b0;
		mem_rden = 1'b0;
		mem_address = '0;
		S_AXI_WDATA = '0;
		S_AXI_WSTRB = '1;
		repeat (5) @(negedge S_AXI_ACLK);
		mpeg_clk = 1'b0;
		check_bit("ts_out_valid", 1'b0, ts_out_valid);
		check_bit("ts_out_sync", 1'b0, ts_out_sync);
		check_bit("monitor_ready", 1'b0, monitor_ready);
		check_word("axi_rdata", '0, axi_rdata);

		passthrough_packets();
		replace_packets();
		monitor_capture();
		ready_hold_and_clear();
		combined_priority();

		repeat (4) @(negedge S_AXI_ACLK);
		$display("errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+bench
src/ts_stream_pkg.sv
src/ts_regs_pkg.sv
src/ts_filter_regs.sv
src/ts_pid_filter.sv
src/ts_monitor_capture.sv
src/ts_remux_top.sv
bench/tb_clock.sv
bench/tb_ts_remux.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_ts_remux -o tb_ts_remux &&
./obj_dir/tb_ts_remux | tee /dev/stderr | grep "All checks passed" > /dev/null ||
{ echo "simulation did not pass"; exit 1; }
